//--- src/axi_pkg.sv
// AXI4 write channel widths and packed payload structs shared by the interconnect
`default_nettype none

package axi_pkg;

   localparam int ADDR_WIDTH      = 32;
   localparam int DATA_BYTES_LOG2 = 2;
   localparam int DATA_BYTES      = 1 << DATA_BYTES_LOG2;    // Bytes per beat
   localparam int DATA_WIDTH      = DATA_BYTES * 8;
   localparam int ID_WIDTH        = 4;
   localparam int USER_WIDTH      = 1;

   typedef struct packed {
      logic [ADDR_WIDTH-1:0] addr;
      logic [2:0]            prot;
      logic [ID_WIDTH-1:0]   id;
      logic [USER_WIDTH-1:0] user;
      logic [7:0]            len;       // Beats in the burst minus one
      logic [2:0]            size;
      logic [1:0]            burst;
      logic                  lock;
      logic [3:0]            cache;
      logic [3:0]            qos;
      logic [3:0]            region;
   } axi_aw_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic [DATA_BYTES-1:0] strb;
      logic                  last;
      logic [USER_WIDTH-1:0] user;
   } axi_w_t;

   typedef struct packed {
      logic [1:0]            resp;
      logic [ID_WIDTH-1:0]   id;
      logic [USER_WIDTH-1:0] user;
   } axi_b_t;

endpackage

`default_nettype wire

//--- src/xbar_pkg.sv
// Grant encoding and arbiter state type for the two-master write interconnect
`default_nettype none

package xbar_pkg;

   // One bit per master, so a grant bit can steer that master's readys directly
   typedef enum logic [1:0] {
      GRANT_NONE = 2'b00,
      GRANT_S0   = 2'b01,
      GRANT_S1   = 2'b10
   } grant_t;

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_ADDR,
      ARB_DATA,
      ARB_RESP
   } arb_state_t;

endpackage

`default_nettype wire

//--- src/axi_wr_arbiter.sv
// Write arbiter that grants one master and holds the grant for a whole burst
`timescale 1ns/1ps
`default_nettype none

module axi_wr_arbiter
   import xbar_pkg::*;
#(
   parameter int ROUND_ROBIN = 1
)
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   s0_awvalid,
   input  logic   s1_awvalid,
   input  logic   aw_fire,
   input  logic   burst_done,
   input  logic   b_fire,
   output grant_t grant,
   output logic   addr_phase,
   output logic   data_phase
);

   arb_state_t state;
   logic       last_s1;                                // High when s1 was served last
   logic       pick_s1;

   // s1 wins alone, or on a tie when it is its turn under round robin
   assign pick_s1 = s1_awvalid & (~s0_awvalid | ((ROUND_ROBIN != 0) & ~last_s1));

   assign addr_phase = (state == ARB_ADDR);            // Only the AW channel may pass
   assign data_phase = (state == ARB_DATA);            // W follows the accepted AW

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state   <= ARB_IDLE;
         grant   <= GRANT_NONE;
         last_s1 <= 1'b1;                              // Lets s0 win the first tie
      end
      else
      begin
         case (state)
            ARB_IDLE:
            begin
               if (s0_awvalid || s1_awvalid)
               begin
                  state   <= ARB_ADDR;
                  grant   <= pick_s1 ? GRANT_S1 : GRANT_S0;
                  last_s1 <= pick_s1;
               end
            end
            ARB_ADDR:
               if (aw_fire)
                  state <= ARB_DATA;
            ARB_DATA:
               if (burst_done)
                  state <= ARB_RESP;
            ARB_RESP:
            begin
               if (b_fire)
               begin
                  state <= ARB_IDLE;
                  grant <= GRANT_NONE;                 // One idle cycle before the next grant
               end
            end
            default:
            begin
               state <= ARB_IDLE;
               grant <= GRANT_NONE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/axi_wr_beat_counter.sv
// Beat counter that loads AWLEN and flags the last accepted W beat of a burst
`timescale 1ns/1ps
`default_nettype none

module axi_wr_beat_counter
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       aw_fire,
   input  logic [7:0] len,
   input  logic       w_fire,
   output logic       burst_done
);

   logic [7:0] remaining;                              // Beats still due after the current one
   logic       active;                                 // A burst is open

   assign burst_done = active & w_fire & (remaining == 8'd0);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         remaining <= 8'd0;
         active    <= 1'b0;
      end
      else if (aw_fire)
      begin
         remaining <= len;
         active    <= 1'b1;
      end
      else if (w_fire && active)
      begin
         if (remaining == 8'd0)
            active <= 1'b0;
         else
            remaining <= remaining - 8'd1;
      end
   end

endmodule

`default_nettype wire

//--- src/axi_wr_mux.sv
// Grant-steered mux of AW and W toward the shared port, with ready and B back to the owner
`timescale 1ns/1ps
`default_nettype none

module axi_wr_mux
   import axi_pkg::*;
   import xbar_pkg::*;
(
   input  grant_t  grant,
   input  logic    addr_phase,
   input  logic    data_phase,

   input  logic    s0_aw_valid,
   output logic    s0_aw_ready,
   input  axi_aw_t s0_aw,
   input  logic    s0_w_valid,
   output logic    s0_w_ready,
   input  axi_w_t  s0_w,
   output logic    s0_b_valid,
   input  logic    s0_b_ready,
   output axi_b_t  s0_b,

   input  logic    s1_aw_valid,
   output logic    s1_aw_ready,
   input  axi_aw_t s1_aw,
   input  logic    s1_w_valid,
   output logic    s1_w_ready,
   input  axi_w_t  s1_w,
   output logic    s1_b_valid,
   input  logic    s1_b_ready,
   output axi_b_t  s1_b,

   output logic    m_aw_valid,
   input  logic    m_aw_ready,
   output axi_aw_t m_aw,
   output logic    m_w_valid,
   input  logic    m_w_ready,
   output axi_w_t  m_w,
   input  logic    m_b_valid,
   output logic    m_b_ready,
   input  axi_b_t  m_b,

   output logic    aw_fire,
   output logic    w_fire,
   output logic    b_fire
);

   always_comb
   begin
      case (grant)
         GRANT_S0:
         begin
            m_aw_valid = s0_aw_valid & addr_phase;
            m_aw       = s0_aw;
            m_w_valid  = s0_w_valid & data_phase;
            m_w        = s0_w;
            m_b_ready  = s0_b_ready;
         end
         GRANT_S1:
         begin
            m_aw_valid = s1_aw_valid & addr_phase;
            m_aw       = s1_aw;
            m_w_valid  = s1_w_valid & data_phase;
            m_w        = s1_w;
            m_b_ready  = s1_b_ready;
         end
         default:
         begin
            m_aw_valid = 1'b0;                         // Nothing leaves without an owner
            m_aw       = '0;
            m_w_valid  = 1'b0;
            m_w        = '0;
            m_b_ready  = 1'b0;
         end
      endcase
   end

   // Each master sees ready and B valid only through its own grant bit
   assign s0_aw_ready = grant[0] & addr_phase & m_aw_ready;
   assign s0_w_ready  = grant[0] & data_phase & m_w_ready;
   assign s0_b_valid  = grant[0] & m_b_valid;
   assign s1_aw_ready = grant[1] & addr_phase & m_aw_ready;
   assign s1_w_ready  = grant[1] & data_phase & m_w_ready;
   assign s1_b_valid  = grant[1] & m_b_valid;

   assign s0_b = m_b;                                  // Payload goes to both, valid picks one
   assign s1_b = m_b;

   assign aw_fire = m_aw_valid & m_aw_ready;
   assign w_fire  = m_w_valid & m_w_ready;
   assign b_fire  = m_b_valid & m_b_ready;

endmodule

`default_nettype wire

//--- src/axi_reg_slice.sv
// One-entry valid/ready register stage for any packed payload type
`timescale 1ns/1ps
`default_nettype none

module axi_reg_slice
#(
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     full;
   payload_t data_q;

   // Accept while empty, or while the held entry leaves this cycle
   assign in_ready  = ~full | out_ready;
   assign out_valid = full;
   assign out_data  = data_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         full <= 1'b0;
      else if (in_ready)
         full <= in_valid;                             // Refill or drain
   end

   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
         data_q <= in_data;
   end

endmodule

`default_nettype wire

//--- src/axi_wr_xbar.sv
// Two-master AXI4 write interconnect sharing one downstream write port
`timescale 1ns/1ps
`default_nettype none

module axi_wr_xbar
   import axi_pkg::*;
   import xbar_pkg::*;
#(
   parameter int ROUND_ROBIN = 1
)
(
   input  logic    clk,
   input  logic    rst_n,

   input  logic    s0_aw_valid,
   output logic    s0_aw_ready,
   input  axi_aw_t s0_aw,
   input  logic    s0_w_valid,
   output logic    s0_w_ready,
   input  axi_w_t  s0_w,
   output logic    s0_b_valid,
   input  logic    s0_b_ready,
   output axi_b_t  s0_b,

   input  logic    s1_aw_valid,
   output logic    s1_aw_ready,
   input  axi_aw_t s1_aw,
   input  logic    s1_w_valid,
   output logic    s1_w_ready,
   input  axi_w_t  s1_w,
   output logic    s1_b_valid,
   input  logic    s1_b_ready,
   output axi_b_t  s1_b,

   output logic    m_aw_valid,
   input  logic    m_aw_ready,
   output axi_aw_t m_aw,
   output logic    m_w_valid,
   input  logic    m_w_ready,
   output axi_w_t  m_w,
   input  logic    m_b_valid,
   output logic    m_b_ready,
   input  axi_b_t  m_b
);

   grant_t  grant;
   logic    addr_phase;
   logic    data_phase;
   logic    aw_fire;
   logic    w_fire;
   logic    b_fire;
   logic    burst_done;
   logic    mux_aw_valid;                              // Owner side of the AW slice
   logic    mux_aw_ready;
   axi_aw_t mux_aw;
   logic    mux_w_valid;                               // Owner side of the W slice
   logic    mux_w_ready;
   axi_w_t  mux_w;

   axi_wr_arbiter #(
      .ROUND_ROBIN (ROUND_ROBIN)
   ) i_axi_wr_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .s0_awvalid (s0_aw_valid),
      .s1_awvalid (s1_aw_valid),
      .aw_fire    (aw_fire),
      .burst_done (burst_done),
      .b_fire     (b_fire),
      .grant      (grant),
      .addr_phase (addr_phase),
      .data_phase (data_phase)
   );

   axi_wr_beat_counter i_axi_wr_beat_counter (
      .clk        (clk),
      .rst_n      (rst_n),
      .aw_fire    (aw_fire),
      .len        (mux_aw.len),                        // Granted master's AWLEN
      .w_fire     (w_fire),
      .burst_done (burst_done)
   );

   axi_wr_mux i_axi_wr_mux (
      .grant       (grant),
      .addr_phase  (addr_phase),
      .data_phase  (data_phase),
      .s0_aw_valid (s0_aw_valid),
      .s0_aw_ready (s0_aw_ready),
      .s0_aw       (s0_aw),
      .s0_w_valid  (s0_w_valid),
      .s0_w_ready  (s0_w_ready),
      .s0_w        (s0_w),
      .s0_b_valid  (s0_b_valid),
      .s0_b_ready  (s0_b_ready),
      .s0_b        (s0_b),
      .s1_aw_valid (s1_aw_valid),
      .s1_aw_ready (s1_aw_ready),
      .s1_aw       (s1_aw),
      .s1_w_valid  (s1_w_valid),
      .s1_w_ready  (s1_w_ready),
      .s1_w        (s1_w),
      .s1_b_valid  (s1_b_valid),
      .s1_b_ready  (s1_b_ready),
      .s1_b        (s1_b),
      .m_aw_valid  (mux_aw_valid),
      .m_aw_ready  (mux_aw_ready),
      .m_aw        (mux_aw),
      .m_w_valid   (mux_w_valid),
      .m_w_ready   (mux_w_ready),
      .m_w         (mux_w),
      .m_b_valid   (m_b_valid),                        // B returns without a slice
      .m_b_ready   (m_b_ready),
      .m_b         (m_b),
      .aw_fire     (aw_fire),
      .w_fire      (w_fire),
      .b_fire      (b_fire)
   );

   axi_reg_slice #(
      .payload_t (axi_aw_t)
   ) i_aw_slice (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (mux_aw_valid),
      .in_ready  (mux_aw_ready),
      .in_data   (mux_aw),
      .out_valid (m_aw_valid),
      .out_ready (m_aw_ready),
      .out_data  (m_aw)
   );

   axi_reg_slice #(
      .payload_t (axi_w_t)
   ) i_w_slice (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (mux_w_valid),
      .in_ready  (mux_w_ready),
      .in_data   (mux_w),
      .out_valid (m_w_valid),
      .out_ready (m_w_ready),
      .out_data  (m_w)
   );

endmodule

`default_nettype wire

//--- bench/axi_wr_xbar_properties.sv
// Concurrent checks on the arbiter grant and the downstream write handshakes of the interconnect
`timescale 1ns/1ps
`default_nettype none

module axi_wr_xbar_properties
   import axi_pkg::*;
   import xbar_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  grant_t  grant,
   input  logic    b_fire,
   input  logic    m_aw_valid,
   input  logic    m_aw_ready,
   input  axi_aw_t m_aw,
   input  logic    m_w_valid,
   input  logic    m_w_ready,
   input  axi_w_t  m_w,
   input  logic    m_b_ready
);

   grant_legal: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
      else $error("Grant has both master bits set");

   // The owner keeps the port until its B response is taken
   grant_held: assert property (@(posedge clk) disable iff (!rst_n)
      (grant != GRANT_NONE && !b_fire) |=> $stable(grant))
      else $error("Grant changed in the middle of a burst");

   aw_held: assert property (@(posedge clk) disable iff (!rst_n)
      (m_aw_valid && !m_aw_ready) |=> (m_aw_valid && $stable(m_aw)))
      else $error("Downstream AW dropped or changed while stalled");

   w_held: assert property (@(posedge clk) disable iff (!rst_n)
      (m_w_valid && !m_w_ready) |=> (m_w_valid && $stable(m_w)))
      else $error("Downstream W dropped or changed while stalled");

   reset_quiet: assert property (@(posedge clk)
      !rst_n |=> (!m_aw_valid && !m_w_valid && !m_b_ready && grant == GRANT_NONE))
      else $error("Valid, ready or grant active right after reset");

endmodule

bind axi_wr_xbar axi_wr_xbar_properties i_axi_wr_xbar_properties (
   .clk        (clk),
   .rst_n      (rst_n),
   .grant      (grant),
   .b_fire     (b_fire),
   .m_aw_valid (m_aw_valid),
   .m_aw_ready (m_aw_ready),
   .m_aw       (m_aw),
   .m_w_valid  (m_w_valid),
   .m_w_ready  (m_w_ready),
   .m_w        (m_w),
   .m_b_ready  (m_b_ready)
);

`default_nettype wire

//--- bench/tb_axi_wr_xbar.sv
// Testbench for the two-master write interconnect with random masters and a downstream slave model
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_xbar
   import axi_pkg::*;
();

   localparam int BURSTS        = 200;                 // Per master
   localparam int PAIRED_BURSTS = 50;                  // Leading bursts issued back to back
   localparam int CYCLE_LIMIT   = 40 * 2 * BURSTS;

   logic        clk;
   logic        rst_n;
   logic        aw_valid [2];
   logic        aw_ready [2];
   axi_aw_t     aw       [2];
   logic        w_valid  [2];
   logic        w_ready  [2];
   axi_w_t      w        [2];
   logic        b_valid  [2];
   logic        b_ready  [2];
   axi_b_t      b        [2];
   logic        m_aw_valid;
   logic        m_aw_ready;
   axi_aw_t     m_aw;
   logic        m_w_valid;
   logic        m_w_ready;
   axi_w_t      m_w;
   logic        m_b_valid;
   logic        m_b_ready;
   axi_b_t      m_b;

   logic [31:0] rng_state;
   axi_aw_t     aw_q  [2][$];                          // Issued AW per master, oldest first
   axi_w_t      w_q   [2][$];                          // Issued W beats per master
   axi_b_t      b_exp [2][$];                          // B answers on their way to each master
   int          owner_log [$];                         // Master of each accepted burst
   axi_b_t      b_log [$];                             // Slave answer for each burst
   int          aw_seen;
   int          w_done;
   int          b_seen;
   int          w_issued;
   int          w_received;
   int          cycle_count;
   int          b_count [2];

   axi_wr_xbar #(
      .ROUND_ROBIN (1)
   ) i_axi_wr_xbar (
      .clk         (clk),
      .rst_n       (rst_n),
      .s0_aw_valid (aw_valid[0]),
      .s0_aw_ready (aw_ready[0]),
      .s0_aw       (aw[0]),
      .s0_w_valid  (w_valid[0]),
      .s0_w_ready  (w_ready[0]),
      .s0_w        (w[0]),
      .s0_b_valid  (b_valid[0]),
      .s0_b_ready  (b_ready[0]),
      .s0_b        (b[0]),
      .s1_aw_valid (aw_valid[1]),
      .s1_aw_ready (aw_ready[1]),
      .s1_aw       (aw[1]),
      .s1_w_valid  (w_valid[1]),
      .s1_w_ready  (w_ready[1]),
      .s1_w        (w[1]),
      .s1_b_valid  (b_valid[1]),
      .s1_b_ready  (b_ready[1]),
      .s1_b        (b[1]),
      .m_aw_valid  (m_aw_valid),
      .m_aw_ready  (m_aw_ready),
      .m_aw        (m_aw),
      .m_w_valid   (m_w_valid),
      .m_w_ready   (m_w_ready),
      .m_w         (m_w),
      .m_b_valid   (m_b_valid),
      .m_b_ready   (m_b_ready),
      .m_b         (m_b)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic axi_aw_t random_aw();
      axi_aw_t     a;
      logic [31:0] r;
      a.addr   = next_rand();
      r        = next_rand();
      a.len    = {5'd0, r[2:0]};                       // One to eight beats
      a.prot   = r[5:3];
      a.id     = r[9:6];
      a.user   = r[10];
      a.cache  = r[14:11];
      a.qos    = r[18:15];
      a.region = r[22:19];
      a.lock   = r[23];
      a.size   = 3'd2;                                 // Full 32-bit beats
      a.burst  = 2'b01;                                // INCR
      return a;
   endfunction

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped after a failure");
   endtask

   task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                              input string msg);
      if (actual !== expected)
      begin
         $display("Mismatch at time %0t: %s (got %0h, expected %0h)",
                  $time, msg, actual, expected);
         $display("RESULT: FAIL");
         $fatal(1, "Value check failed");
      end
   endtask

   task automatic run_master(input int idx);
      axi_aw_t     a;
      axi_w_t      beat_w;
      logic [31:0] r;
      int          gap;
      for (int n = 0; n < BURSTS; n++)
      begin
         a   = random_aw();
         r   = next_rand();
         gap = (n < PAIRED_BURSTS) ? 0 : int'(r[1:0]);
         repeat (gap) @(negedge clk);
         aw_q[idx].push_back(a);
         aw[idx]       = a;
         aw_valid[idx] = 1'b1;
         @(posedge clk);
         while (!aw_ready[idx]) @(posedge clk);
         owner_log.push_back(idx);                     // Only the granted master sees AWREADY
         @(negedge clk);
         aw_valid[idx] = 1'b0;
         for (int beat = 0; beat <= int'(a.len); beat++)
         begin
            r           = next_rand();
            beat_w.data = next_rand();
            beat_w.strb = r[3:0];
            beat_w.last = (beat == int'(a.len));
            beat_w.user = r[4];
            w_q[idx].push_back(beat_w);
            w_issued++;
            w[idx]       = beat_w;
            w_valid[idx] = 1'b1;
            @(posedge clk);
            while (!w_ready[idx]) @(posedge clk);
            @(negedge clk);
         end
         w_valid[idx] = 1'b0;
      end
   endtask

   task automatic drive_slave_ready();
      logic [31:0] r;
      forever
      begin
         @(negedge clk);
         r          = next_rand();
         m_aw_ready = (r[1:0] != 2'b00);               // Ready about three cycles in four
         m_w_ready  = (r[3:2] != 2'b00);
      end
   endtask

   task automatic drive_b_responses();
      logic [31:0] r;
      int          owner;
      forever
      begin
         @(negedge clk);
         if (aw_seen > b_seen && w_done > b_seen)      // Address and last beat both arrived
         begin
            r = next_rand();
            repeat (int'(r[1:0])) @(negedge clk);
            owner     = owner_log[b_seen];
            m_b       = b_log[b_seen];
            m_b_valid = 1'b1;
            b_exp[owner].push_back(b_log[b_seen]);
            @(posedge clk);
            while (!m_b_ready) @(posedge clk);
            b_seen++;
            @(negedge clk);
            m_b_valid = 1'b0;
         end
      end
   endtask

   task automatic receive_b(input int idx);
      logic [31:0] r;
      axi_b_t      exp_b;
      forever
      begin
         @(negedge clk);
         r            = next_rand();
         b_ready[idx] = (r[1:0] != 2'b00);
         @(posedge clk);
         if (b_valid[idx])
         begin
            if (b_exp[idx].size() == 0)
               stop_with_failure("A B response reached a master that has no burst open");
            if (b_ready[idx])
            begin
               exp_b = b_exp[idx].pop_front();
               check_equal(128'(b[idx]), 128'(exp_b), "B response id, resp and user");
               b_count[idx]++;
            end
         end
      end
   endtask

   task automatic check_aw();
      int      owner;
      axi_aw_t exp_aw;
      axi_b_t  answer;
      if (aw_seen >= owner_log.size())
         stop_with_failure("A downstream AW appeared with no AW accepted from a master");
      check_equal(128'(aw_seen), 128'(b_seen), "AW of a new burst before the previous B");
      owner = owner_log[aw_seen];
      if (aw_seen < 2 * PAIRED_BURSTS)                 // Both masters are pending here
         check_equal(128'(owner), 128'(aw_seen % 2), "round-robin order of served masters");
      exp_aw = aw_q[owner].pop_front();
      check_equal(128'(m_aw), 128'(exp_aw), "downstream AW fields");
      answer.resp = m_aw.addr[5:4];
      answer.id   = m_aw.id;
      answer.user = m_aw.user;                         // Echoes AWUSER so both user values travel back
      b_log.push_back(answer);
      aw_seen++;
   endtask

   task automatic check_w();
      int     owner;
      axi_w_t exp_w;
      if (w_done >= owner_log.size())
         stop_with_failure("A downstream W beat appeared with no AW accepted for it");
      check_equal(128'(w_done), 128'(b_seen), "W beat of a new burst before the previous B");
      owner = owner_log[w_done];
      if (w_q[owner].size() == 0)
         stop_with_failure("More W beats reached the slave than the master sent");
      exp_w = w_q[owner].pop_front();
      check_equal(128'(m_w), 128'(exp_w), "downstream W data, strobe and last");
      w_received++;
      if (m_w.last)
         w_done++;
   endtask

   always @(posedge clk)
   begin
      if (rst_n && m_aw_valid && m_aw_ready)
         check_aw();
      if (rst_n && m_w_valid && m_w_ready)
         check_w();
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT)
         stop_with_failure("Timeout: the bursts did not finish within the cycle limit");
   end

   initial
   begin
      rng_state = 32'hdb3a;
      rst_n     = 1'b0;
      for (int i = 0; i < 2; i++)
      begin
         aw_valid[i] = 1'b0;
         aw[i]       = '0;
         w_valid[i]  = 1'b0;
         w[i]        = '0;
         b_ready[i]  = 1'b0;
      end
      m_aw_ready = 1'b0;
      m_w_ready  = 1'b0;
      m_b_valid  = 1'b0;
      m_b        = '0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      fork
         drive_slave_ready();
         drive_b_responses();
         receive_b(0);
         receive_b(1);
      join_none
      fork
         run_master(0);
         run_master(1);
      join
      while (b_count[0] < BURSTS || b_count[1] < BURSTS) @(posedge clk);
      check_equal(128'(w_received), 128'(w_issued), "total W beats at the slave");
      check_equal(128'(aw_seen), 128'(2 * BURSTS), "total AW at the slave");
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
src/axi_pkg.sv
src/xbar_pkg.sv
src/axi_wr_arbiter.sv
src/axi_wr_beat_counter.sv
src/axi_wr_mux.sv
src/axi_reg_slice.sv
src/axi_wr_xbar.sv
bench/axi_wr_xbar_properties.sv
bench/tb_axi_wr_xbar.sv

//--- Makefile
# Verilator build and run of the two-master AXI4 write interconnect testbench

TOP  := tb_axi_wr_xbar
SRCS := $(wildcard src/*.sv bench/*.sv)

obj_dir/V$(TOP): project.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f project.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: run clean
